// File: source/mipsPkg.sv
package mipsPkg;

    // ########################################
    // Instruction word
    // ########################################

    // The same 32 bits are read as R-, I- or J-format depending on the opcode.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } jFmt;
    } instrWord;

    // ########################################
    // Encodings
    // ########################################

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSltiu   = 6'h0b;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnJalr = 6'h09;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    // ########################################
    // Control field codes
    // ########################################

    localparam logic [2:0] aluAdd  = 3'd0;
    localparam logic [2:0] aluSub  = 3'd1;
    localparam logic [2:0] aluAnd  = 3'd2;
    localparam logic [2:0] aluOr   = 3'd3;
    localparam logic [2:0] aluSlt  = 3'd4;
    localparam logic [2:0] aluSltu = 3'd5;
    localparam logic [2:0] aluLui  = 3'd6;

    localparam logic extZero = 1'b0;
    localparam logic extSign = 1'b1;

    localparam logic [1:0] pcSeq    = 2'd0;
    localparam logic [1:0] pcBranch = 2'd1;
    localparam logic [1:0] pcJump   = 2'd2;
    localparam logic [1:0] pcReg    = 2'd3;

    localparam logic [1:0] wbAlu  = 2'd0;
    localparam logic [1:0] wbMem  = 2'd1;
    localparam logic [1:0] wbLink = 2'd2;

    localparam logic [1:0] dstRt = 2'd0;
    localparam logic [1:0] dstRd = 2'd1;
    localparam logic [1:0] dstRa = 2'd2;

    localparam logic stateFetch = 1'b0;
    localparam logic stateExec  = 1'b1;

    localparam logic [31:0] resetVector = 32'h0000_0040;
    localparam logic [31:0] haltAddress = 32'h0000_0000;
    localparam logic [4:0]  regV0       = 5'd2;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  op,
    output logic [31:0] result,
    output logic        zero
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        ltSigned;
    logic        ltUnsigned;

    // ########################################
    // Shared arithmetic
    // ########################################

    assign sum  = a + b;
    assign diff = a - b;

    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    // ########################################
    // Result select
    // ########################################

    always_comb begin
        case (op)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {31'b0, ltSigned};
            aluSltu: result = {31'b0, ltUnsigned};
            // The immediate moves to the upper half, rs is ignored.
            aluLui:  result = {b[15:0], 16'b0};
            default: result = 32'b0;
        endcase
    end

    // Beq and bne subtract and look at this flag.
    assign zero = (result == 32'b0);

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (we && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Register zero is hardwired.
    assign rdDataA = (rdAddrA == 5'd0) ? 32'b0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? 32'b0 : regs[rdAddrB];

    assign v0 = regs[regV0];

endmodule

// File: source/controlPath.sv
`timescale 1ns/1ps

module controlPath import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  instrWord    instr,
    input  logic        aluZero,
    input  logic [31:0] nextPc,
    output logic        active,
    output logic        irEn,
    output logic        pcEn,
    output logic        addrSrc,
    output logic        regWe,
    output logic [1:0]  regDst,
    output logic        bSrc,
    output logic        extSel,
    output logic [2:0]  aluOp,
    output logic [1:0]  pcSrc,
    output logic [1:0]  wbSel,
    output logic        memWe
);

    logic       state;
    logic       isRFmt;
    logic       isJFmt;
    logic       isBranch;
    logic       isJump;
    logic       decRegWe;
    logic       decMemWe;
    logic       execNow;
    logic [5:0] opcode;
    logic [5:0] funct;

    // ########################################
    // Fetch / execute sequencing
    // ########################################

    assign execNow = (state == stateExec) && active;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= stateFetch;
            active <= 1'b1;
        end else begin
            state <= (state == stateFetch && active) ? stateExec : stateFetch;
            // A jump to the halt address ends the program.
            if (execNow && isJump && nextPc == haltAddress) begin
                active <= 1'b0;
            end
        end
    end

    assign irEn    = (state == stateFetch) && active;
    assign addrSrc = (state == stateFetch);
    assign pcEn    = execNow;
    assign regWe   = execNow && decRegWe;
    assign memWe   = execNow && decMemWe;

    // ########################################
    // Decoder
    // ########################################

    assign opcode   = instr.rFmt.opcode;
    assign funct    = instr.rFmt.funct;
    assign isRFmt   = (opcode == opSpecial);
    assign isJFmt   = (opcode == opJ) || (opcode == opJal);
    assign isBranch = (opcode == opBeq) || (opcode == opBne);
    assign isJump   = isJFmt || (isRFmt && pcSrc == pcReg);

    // Branches compare two registers, so they take rt like R-format.
    assign bSrc = isRFmt || isBranch;

    always_comb begin
        decRegWe = 1'b0;
        decMemWe = 1'b0;
        regDst   = dstRt;
        extSel   = extSign;
        aluOp    = aluAdd;
        pcSrc    = pcSeq;
        wbSel    = wbAlu;
        case (opcode)
            opSpecial: begin
                regDst = dstRd;
                case (funct)
                    fnAddu: begin
                        decRegWe = 1'b1;
                        aluOp    = aluAdd;
                    end
                    fnSubu: begin
                        decRegWe = 1'b1;
                        aluOp    = aluSub;
                    end
                    fnAnd: begin
                        decRegWe = 1'b1;
                        aluOp    = aluAnd;
                    end
                    fnOr: begin
                        decRegWe = 1'b1;
                        aluOp    = aluOr;
                    end
                    fnSlt: begin
                        decRegWe = 1'b1;
                        aluOp    = aluSlt;
                    end
                    fnSltu: begin
                        decRegWe = 1'b1;
                        aluOp    = aluSltu;
                    end
                    fnJr:   pcSrc = pcReg;
                    fnJalr: begin
                        decRegWe = 1'b1;
                        pcSrc    = pcReg;
                        wbSel    = wbLink;
                    end
                    default: ;
                endcase
            end
            opJ:   pcSrc = pcJump;
            opJal: begin
                decRegWe = 1'b1;
                regDst   = dstRa;
                pcSrc    = pcJump;
                wbSel    = wbLink;
            end
            opBeq: begin
                aluOp = aluSub;
                pcSrc = aluZero ? pcBranch : pcSeq;
            end
            opBne: begin
                aluOp = aluSub;
                pcSrc = aluZero ? pcSeq : pcBranch;
            end
            opAddiu: decRegWe = 1'b1;
            opSltiu: begin
                decRegWe = 1'b1;
                aluOp    = aluSltu;
            end
            opAndi: begin
                decRegWe = 1'b1;
                aluOp    = aluAnd;
                extSel   = extZero;
            end
            opOri: begin
                decRegWe = 1'b1;
                aluOp    = aluOr;
                extSel   = extZero;
            end
            opLui: begin
                decRegWe = 1'b1;
                aluOp    = aluLui;
                extSel   = extZero;
            end
            opLw: begin
                decRegWe = 1'b1;
                wbSel    = wbMem;
            end
            opSw:    decMemWe = 1'b1;
            default: ;
        endcase
    end

    // Architectural state only changes in the cycle right after a fetch.
    assert property (@(posedge clk) disable iff (!rstN)
        (memWe || regWe) |-> $past(irEn));

    // A link write must land in a real register.
    assert property (@(posedge clk) disable iff (!rstN)
        (regWe && wbSel == wbLink) |-> !(regDst == dstRd && instr.rFmt.rd == 5'd0));

endmodule

// File: source/dataPath.sv
`timescale 1ns/1ps

module dataPath import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        irEn,
    input  logic        pcEn,
    input  logic        addrSrc,
    input  logic        regWe,
    input  logic [1:0]  regDst,
    input  logic        bSrc,
    input  logic        extSel,
    input  logic [2:0]  aluOp,
    input  logic [1:0]  pcSrc,
    input  logic [1:0]  wbSel,
    input  logic [31:0] memRdData,
    output instrWord    instr,
    output logic        aluZero,
    output logic [31:0] nextPc,
    output logic [31:0] memAddr,
    output logic [31:0] memWrData,
    output logic [31:0] registerV0
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] immExt;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] wbData;
    logic [4:0]  wrAddr;

    // ########################################
    // Program counter and instruction register
    // ########################################

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetVector;
        end else if (pcEn) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (irEn) begin
            instr <= memRdData;
        end
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSrc)
            pcBranch: nextPc = pcPlus4 + {immExt[29:0], 2'b00};
            pcJump:   nextPc = {pcPlus4[31:28], instr.jFmt.target, 2'b00};
            pcReg:    nextPc = rdDataA;
            default:  nextPc = pcPlus4;
        endcase
    end

    // ########################################
    // Operands and write-back
    // ########################################

    assign immExt = (extSel == extSign) ? {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm}
                                        : {16'b0, instr.iFmt.imm};
    assign aluB   = bSrc ? rdDataB : immExt;

    always_comb begin
        case (regDst)
            dstRd:   wrAddr = instr.rFmt.rd;
            dstRa:   wrAddr = 5'd31;
            default: wrAddr = instr.iFmt.rt;
        endcase
    end

    always_comb begin
        case (wbSel)
            wbMem:   wbData = memRdData;
            wbLink:  wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // The PC addresses memory while fetching, the ALU result while executing.
    assign memAddr   = addrSrc ? pc : aluResult;
    assign memWrData = rdDataB;

    regFile regFileInst (
        .clk     (clk),
        .rstN    (rstN),
        .we      (regWe),
        .rdAddrA (instr.iFmt.rs),
        .rdAddrB (instr.iFmt.rt),
        .wrAddr  (wrAddr),
        .wrData  (wbData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .v0      (registerV0)
    );

    alu aluInst (
        .a      (rdDataA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

// File: source/mipsCpu.sv
`timescale 1ns/1ps

module mipsCpu import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] memRdData,
    output logic [31:0] memAddr,
    output logic [31:0] memWrData,
    output logic        memWe,
    output logic        active,
    output logic [31:0] registerV0
);

    instrWord    instr;
    logic        aluZero;
    logic [31:0] nextPc;
    logic        irEn;
    logic        pcEn;
    logic        addrSrc;
    logic        regWe;
    logic [1:0]  regDst;
    logic        bSrc;
    logic        extSel;
    logic [2:0]  aluOp;
    logic [1:0]  pcSrc;
    logic [1:0]  wbSel;

    controlPath controlPathInst (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .aluZero (aluZero),
        .nextPc  (nextPc),
        .active  (active),
        .irEn    (irEn),
        .pcEn    (pcEn),
        .addrSrc (addrSrc),
        .regWe   (regWe),
        .regDst  (regDst),
        .bSrc    (bSrc),
        .extSel  (extSel),
        .aluOp   (aluOp),
        .pcSrc   (pcSrc),
        .wbSel   (wbSel),
        .memWe   (memWe)
    );

    dataPath dataPathInst (
        .clk        (clk),
        .rstN       (rstN),
        .irEn       (irEn),
        .pcEn       (pcEn),
        .addrSrc    (addrSrc),
        .regWe      (regWe),
        .regDst     (regDst),
        .bSrc       (bSrc),
        .extSel     (extSel),
        .aluOp      (aluOp),
        .pcSrc      (pcSrc),
        .wbSel      (wbSel),
        .memRdData  (memRdData),
        .instr      (instr),
        .aluZero    (aluZero),
        .nextPc     (nextPc),
        .memAddr    (memAddr),
        .memWrData  (memWrData),
        .registerV0 (registerV0)
    );

endmodule

// File: tb/mipsCpuTb.sv
`timescale 1ns/1ps

module mipsCpuTb import mipsPkg::*; ();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 4;
    localparam int haltMargin  = 8;
    localparam int memWords    = 1024;
    localparam int randomCount = 20;

    localparam int lenArith     = 15;
    localparam int lenLogic     = 10;
    localparam int lenLoadStore = 8;
    localparam int lenBranch    = 16;
    localparam int lenCall      = 12;
    localparam int lenRandom    = randomCount + 3;
    localparam int totalLen     = lenArith + lenLogic + lenLoadStore + lenBranch
                                + lenCall + lenRandom;
    localparam int watchdogNs   = totalLen * 2 * clkPeriod + 2000;

    localparam logic [4:0] rZero = 5'd0;
    localparam logic [4:0] rT0   = 5'd8;
    localparam logic [4:0] rT1   = 5'd9;
    localparam logic [4:0] rT2   = 5'd10;
    localparam logic [4:0] rT3   = 5'd11;
    localparam logic [4:0] rT4   = 5'd12;
    localparam logic [4:0] rT5   = 5'd13;
    localparam logic [4:0] rT6   = 5'd14;
    localparam logic [4:0] rRa   = 5'd31;

    logic        clk;
    logic        rstN;
    logic [31:0] memRdData;
    logic [31:0] memAddr;
    logic [31:0] memWrData;
    logic        memWe;
    logic        active;
    logic [31:0] registerV0;

    logic [31:0] mem [memWords];
    logic [9:0]  loadIndex;
    int          emitted;
    logic        storePending;
    logic [9:0]  storeIdx;
    logic [31:0] storeData;

    mipsCpu mipsCpu_inst (
        .clk        (clk),
        .rstN       (rstN),
        .memRdData  (memRdData),
        .memAddr    (memAddr),
        .memWrData  (memWrData),
        .memWe      (memWe),
        .active     (active),
        .registerV0 (registerV0)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        abortRun("Watchdog expired: the tests did not finish in time.");
    end

    // ########################################
    // Reporting and checks
    // ########################################

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string testName, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("error: %s %s expected %h actual %h",
                               testName, what, expected, actual));
        end
    endtask

    task automatic checkCycles(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            abortRun($sformatf("error: %s cycles expected %0d actual %0d",
                               testName, expected, actual));
        end
    endtask

    // ########################################
    // Instruction encoding and extension
    // ########################################

    function automatic logic [31:0] rWord(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {opSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(input logic [5:0] op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    function automatic logic [31:0] signExtend16(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    function automatic logic [31:0] zeroExtend16(input logic [15:0] value);
        return {16'h0000, value};
    endfunction

    function automatic logic [9:0] wordIndex(input logic [31:0] addr);
        return addr[11:2];
    endfunction

    // ########################################
    // Memory model and sequencing
    // ########################################

    // Unused words decode as unknown opcodes, which the CPU treats as no-ops.
    task automatic fillMemory;
        logic [31:0] byteAddr;
        for (int i = 0; i < memWords; i++) begin
            byteAddr = 32'(i) << 2;
            mem[10'(i)] = byteAddr ^ 32'hdead_0000;
        end
    endtask

    task automatic startProgram;
        fillMemory();
        loadIndex = wordIndex(resetVector);
        emitted = 0;
    endtask

    task automatic placeWord(input logic [31:0] word);
        mem[loadIndex] = word;
        loadIndex = loadIndex + 10'd1;
        emitted++;
    endtask

    // Called on the falling edge, when the bus outputs are settled.
    task automatic sampleBus;
        storePending = memWe;
        storeIdx = memAddr[11:2];
        storeData = memWrData;
        memRdData = mem[memAddr[11:2]];
    endtask

    task automatic stepCycle;
        @(posedge clk);
        if (storePending) begin
            mem[storeIdx] = storeData;
        end
        @(negedge clk);
        sampleBus();
    endtask

    task automatic pulseReset;
        storePending = 1'b0;
        @(negedge clk);
        rstN = 1'b0;
        repeat (resetCycles) begin
            @(posedge clk);
            @(negedge clk);
        end
        sampleBus();
        rstN = 1'b1;
    endtask

    task automatic runProgram(input string testName, input int expectedLen, output int cycles);
        int limit;
        limit = 2 * emitted + haltMargin;
        if (emitted != expectedLen) begin
            abortRun($sformatf("%s: program holds %0d words where %0d were expected.",
                               testName, emitted, expectedLen));
        end
        pulseReset();
        cycles = 0;
        while (active && cycles < limit) begin
            stepCycle();
            cycles++;
        end
        if (active) begin
            abortRun($sformatf("%s: the CPU did not halt within %0d cycles.",
                               testName, limit));
        end
    endtask

    // ########################################
    // Directed tests
    // ########################################

    task automatic arithmeticCompare;
        logic [31:0] k1, k2, slt, ltA, ltB, expected;
        int cycles;
        k1 = signExtend16(16'h1234);
        k2 = signExtend16(16'hfff0);
        slt = ($signed(k2) < $signed(k1)) ? 32'd1 : 32'd0;
        ltA = (k2 < k1) ? 32'd1 : 32'd0;
        ltB = (k1 < k2) ? 32'd1 : 32'd0;
        expected = (k1 + k2) + (k2 - k1) + slt + (ltA << 2) + (ltB << 1);
        startProgram();
        placeWord(iWord(opAddiu, rT0, rZero, 16'h1234));
        placeWord(iWord(opAddiu, rT1, rZero, 16'hfff0));
        placeWord(rWord(fnAddu, rT2, rT0, rT1));
        placeWord(rWord(fnSubu, rT3, rT1, rT0));
        placeWord(rWord(fnSlt, rT4, rT1, rT0));
        placeWord(rWord(fnSltu, rT5, rT1, rT0));
        placeWord(rWord(fnSltu, rT6, rT0, rT1));
        placeWord(rWord(fnAddu, rT5, rT5, rT5));
        placeWord(rWord(fnAddu, rT5, rT5, rT5));
        placeWord(rWord(fnAddu, rT6, rT6, rT6));
        placeWord(rWord(fnAddu, regV0, rT2, rT3));
        placeWord(rWord(fnAddu, regV0, regV0, rT4));
        placeWord(rWord(fnAddu, regV0, regV0, rT5));
        placeWord(rWord(fnAddu, regV0, regV0, rT6));
        placeWord(jWord(opJ, haltAddress));
        runProgram("arithmetic", lenArith, cycles);
        checkCycles("arithmetic", 2 * lenArith, cycles);
        checkWord("arithmetic", "v0", expected, registerV0);
    endtask

    task automatic logicImmediates;
        logic [31:0] t0, t1, t2, t3, expected;
        int cycles;
        // Logical immediates are zero extended, addiu and sltiu sign extend.
        t0 = {16'h8001, 16'h0000} | zeroExtend16(16'hf00f);
        t1 = t0 & zeroExtend16(16'hff00);
        t2 = signExtend16(16'h8000);
        t3 = (t1 < signExtend16(16'hffff)) ? 32'd1 : 32'd0;
        expected = ((t0 & t2) | t1) + t3 + t2;
        startProgram();
        placeWord(iWord(opLui, rT0, rZero, 16'h8001));
        placeWord(iWord(opOri, rT0, rT0, 16'hf00f));
        placeWord(iWord(opAndi, rT1, rT0, 16'hff00));
        placeWord(iWord(opAddiu, rT2, rZero, 16'h8000));
        placeWord(iWord(opSltiu, rT3, rT1, 16'hffff));
        placeWord(rWord(fnAnd, rT4, rT0, rT2));
        placeWord(rWord(fnOr, regV0, rT4, rT1));
        placeWord(rWord(fnAddu, regV0, regV0, rT3));
        placeWord(rWord(fnAddu, regV0, regV0, rT2));
        placeWord(jWord(opJ, haltAddress));
        runProgram("logicImm", lenLogic, cycles);
        checkWord("logicImm", "v0", expected, registerV0);
    endtask

    task automatic loadStore;
        logic [31:0] stored;
        int cycles;
        stored = {16'hcafe, 16'h1234};
        startProgram();
        placeWord(iWord(opAddiu, rT0, rZero, 16'h0200));
        placeWord(iWord(opLui, rT1, rZero, 16'hcafe));
        placeWord(iWord(opOri, rT1, rT1, 16'h1234));
        placeWord(iWord(opSw, rT1, rT0, 16'h0008));
        placeWord(iWord(opLw, regV0, rT0, 16'h0008));
        placeWord(iWord(opAddiu, rT0, rT0, 16'h0010));
        placeWord(iWord(opSw, regV0, rT0, 16'hfffc));
        placeWord(jWord(opJ, haltAddress));
        runProgram("loadStore", lenLoadStore, cycles);
        checkWord("loadStore", "mem[0x208]", stored, mem[wordIndex(32'h0000_0208)]);
        checkWord("loadStore", "mem[0x20c]", stored, mem[wordIndex(32'h0000_020c)]);
        checkWord("loadStore", "v0", stored, registerV0);
    endtask

    task automatic branchOutcomes;
        logic [31:0] expected;
        int cycles;
        // Taken beq 0x10, untaken beq 0x100, taken bne 0x2000, untaken bne 0x4000.
        expected = 32'h0010 + 32'h0100 + 32'h0200 + 32'h2000 + 32'h4000 + 32'h0800;
        startProgram();
        placeWord(iWord(opAddiu, rT0, rZero, 16'd5));
        placeWord(iWord(opAddiu, rT1, rZero, 16'd5));
        placeWord(iWord(opAddiu, rT2, rZero, 16'd7));
        placeWord(iWord(opBeq, rT1, rT0, 16'd1));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0001));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0010));
        placeWord(iWord(opBeq, rT2, rT0, 16'd1));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0100));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0200));
        placeWord(iWord(opBne, rT2, rT0, 16'd1));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h1000));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h2000));
        placeWord(iWord(opBne, rT1, rT0, 16'd1));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h4000));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0800));
        placeWord(jWord(opJ, haltAddress));
        runProgram("branches", lenBranch, cycles);
        checkWord("branches", "v0", expected, registerV0);
    endtask

    task automatic callReturn;
        logic [31:0] sub1Addr, sub2Addr, expected;
        int cycles;
        sub1Addr = resetVector + 32'd32;
        sub2Addr = resetVector + 32'd40;
        // Both links are the address after the call instruction.
        expected = 32'h0020 + 32'h0100 + (resetVector + 32'd4)
                 + 32'h0040 + (resetVector + 32'd20);
        startProgram();
        placeWord(jWord(opJal, sub1Addr));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0100));
        placeWord(rWord(fnAddu, regV0, regV0, rRa));
        placeWord(iWord(opAddiu, rT0, rZero, sub2Addr[15:0]));
        placeWord(rWord(fnJalr, rRa, rT0, rZero));
        placeWord(rWord(fnAddu, regV0, regV0, rRa));
        placeWord(jWord(opJ, haltAddress));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h7000));
        placeWord(iWord(opAddiu, regV0, rZero, 16'h0020));
        placeWord(rWord(fnJr, rZero, rRa, rZero));
        placeWord(iWord(opAddiu, regV0, regV0, 16'h0040));
        placeWord(rWord(fnJr, rZero, rRa, rZero));
        runProgram("calls", lenCall, cycles);
        checkWord("calls", "v0", expected, registerV0);
    endtask

    task automatic randomSums;
        logic [15:0] imm;
        logic [31:0] expected;
        int cycles;
        expected = 32'd0;
        startProgram();
        for (int i = 0; i < randomCount; i++) begin
            imm = 16'($urandom);
            placeWord(iWord(opAddiu, regV0, regV0, imm));
            expected = expected + signExtend16(imm);
        end
        // Writes to register zero are dropped, and it still reads as zero.
        placeWord(rWord(fnAddu, rZero, regV0, regV0));
        placeWord(rWord(fnAddu, regV0, regV0, rZero));
        placeWord(jWord(opJ, haltAddress));
        runProgram("randomSums", lenRandom, cycles);
        checkWord("randomSums", "v0", expected, registerV0);
    endtask

    initial begin
        rstN = 1'b0;
        memRdData = 32'd0;
        storePending = 1'b0;
        storeIdx = 10'd0;
        storeData = 32'd0;
        loadIndex = 10'd0;
        emitted = 0;
        void'($urandom(17));
        arithmeticCompare();
        logicImmediates();
        loadStore();
        branchOutcomes();
        callReturn();
        randomSums();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tb.f
source/mipsPkg.sv
source/alu.sv
source/regFile.sv
source/controlPath.sv
source/dataPath.sv
source/mipsCpu.sv
tb/mipsCpuTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mipsCpuTb -f tb.f -o mipsCpuSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/mipsCpuSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
